/* build.f */
+incdir+rtl
rtl/spc_pkg.sv
rtl/spc_input_conditioner.sv
rtl/spc_channel_counter.sv
rtl/spc_result_writer.sv
rtl/spc_photon_counter.sv
sim/spc_props.sv
sim/spc_tb.sv

/* sim/spc_tb.sv */
`timescale 1ns/100ps
`include "spc_consts.svh"

module spc_tb import spc_pkg::*; ;

    localparam int CH = `SPC_CHANNELS;

    logic                   clk_133MHz_210;
    logic                   rst_n;
    logic [CH-1:0]          photon_in;
    logic                   sync_50hz;
    logic                   wr_req;
    mem_wr_t                wr_cmd;
    logic                   wr_done;
    logic                   overrun;

    logic [31:0]            lfsr_q = 32'hcaf1;
    int                     hold [CH];       // Cycles left at this level.
    logic [CH-1:0]          manual;          // Lanes driven by the main flow.
    logic                   photons_on;
    logic                   stall;           // Memory holds off wr_done.

    always #50 clk_133MHz_210 = ~clk_133MHz_210;

    spc_photon_counter u_dut (.*);

    bind spc_photon_counter spc_props u_props (.*);

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = (v << 1) | fb;
        end
        return v;
    endfunction

    task automatic timeout(input string what);
        $display("Testbench failed");
        $fatal(1, "Timeout while waiting for %s", what);
    endtask

    // First assertion failure ends the run.
    always @(u_dut.u_props.fails) begin
        if (u_dut.u_props.fails != 0) begin
            $display("Testbench failed");
            $fatal(1, "Assertion failure in spc_props");
        end
    end

    ////////////////////////////////////////////////////////////
    // Photon stimulus and frame memory.
    ////////////////////////////////////////////////////////////

    always @(posedge clk_133MHz_210) begin
        #1;
        if (photons_on) begin
            for (int i = 0; i < CH; i++) begin
                if (!manual[i]) begin
                    if (hold[i] == 0) begin
                        photon_in[i] = ~photon_in[i];
                        hold[i]      = 1 + rand_bits(2);  // Level lasts 2 to 5.
                    end else begin
                        hold[i]--;
                    end
                end
            end
        end
    end

    initial begin
        int delay;
        int n;
        forever begin
            @(posedge clk_133MHz_210);
            if (wr_req) begin
                delay = rand_bits(3);  // 0 to 7 cycles.
                repeat (delay) @(posedge clk_133MHz_210);
                n = 0;
                while (stall) begin
                    @(posedge clk_133MHz_210);
                    n++;
                    if (n > 20000) timeout("the memory stall to end");
                end
                #1 wr_done = 1'b1;
                @(posedge clk_133MHz_210);
                #1 wr_done = 1'b0;
            end
        end
    end

    // Sync edge 400 to 600 cycles after the last one.
    task automatic close_window(input logic align);
        int gap;
        @(negedge clk_133MHz_210);
        gap = 400 + (rand_bits(8) * 200) / 255;
        repeat (gap - 12) @(posedge clk_133MHz_210);
        if (align) begin
            manual[0] = 1'b1;  // Lane 0 keeps its level from here.
        end
        repeat (4) @(posedge clk_133MHz_210);
        if (align) begin
            #1;
            photon_in[0] = 1'b0;  // Low before the shared edge.
        end
        repeat (4) @(posedge clk_133MHz_210);
        #1;
        sync_50hz = 1'b1;
        if (align) photon_in[0] = 1'b1;  // Lands on the tick cycle.
        repeat (4) @(posedge clk_133MHz_210);
        manual = '0;
        #1;
        sync_50hz = 1'b0;
    endtask

    task automatic drain();
        int idle;
        int n;
        idle = 0;
        n    = 0;
        while (idle < 16) begin
            @(posedge clk_133MHz_210);
            idle = wr_req ? 0 : idle + 1;
            n++;
            if (n > 5000) timeout("the writer to go idle");
        end
    endtask

    task automatic wait_overrun();
        int n;
        n = 0;
        while (!overrun) begin
            @(posedge clk_133MHz_210);
            n++;
            if (n > 2000) timeout("overrun");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main flow.
    ////////////////////////////////////////////////////////////

    initial begin
        clk_133MHz_210 = 1'b0;
        rst_n          = 1'b0;
        photon_in      = '0;
        sync_50hz      = 1'b0;
        wr_done        = 1'b0;
        stall          = 1'b0;
        manual         = '0;
        photons_on     = 1'b0;
        for (int i = 0; i < CH; i++) hold[i] = 0;
        repeat (4) @(posedge clk_133MHz_210);
        photons_on = 1'b1;
        #1;
        rst_n = 1'b1;

        for (int w = 0; w < 12; w++) begin
            close_window(w == 3);  // Window 3 ends with a coincident pulse.
        end
        drain();

        // Memory stalls across two ticks.
        stall = 1'b1;
        close_window(1'b0);
        close_window(1'b0);
        wait_overrun();
        stall = 1'b0;
        drain();
        close_window(1'b0);
        drain();

        if (u_dut.u_props.fails == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "Assertion failures seen");
        end
    end

endmodule

/* sim/spc_props.sv */
`timescale 1ns/100ps
`include "spc_consts.svh"

module spc_props import spc_pkg::*; (
    input logic                     clk_133MHz_210,
    input logic                     rst_n,
    input logic [`SPC_CHANNELS-1:0] photon_in,
    input logic                     sync_50hz,
    input logic                     wr_req,
    input mem_wr_t                  wr_cmd,
    input logic                     wr_done,
    input logic                     overrun
);

    localparam int CH = `SPC_CHANNELS;

    int fails = 0;  // Read by the testbench.

    logic [CH:0]              d1, d2, d3;   // Pin samples with sync on top.
    logic [CH:0]              rp;           // Edges 3 cycles after the pin.
    logic [`SPC_COUNT_W-1:0]  cnt [CH];     // Running reference counts.
    logic [`SPC_COUNT_W-1:0]  rec_cnt [CH]; // Closed window counts.
    logic [`SPC_WIN_W-1:0]    rec_win [CH];
    logic [`SPC_WIN_W-1:0]    win;
    logic [CH-1:0]            pend, pend_d;
    logic                     ovr;
    logic                     seen_tick;
    logic                     req_d;
    logic                     lo_next;      // Next word is the low half.
    int                       lane_q, lane_now;
    logic [`SPC_ADDR_W-1:0]   exp_addr;
    logic [`SPC_DATA_W-1:0]   exp_data;

    function automatic int lowest(input logic [CH-1:0] p);
        int l;
        l = 0;
        for (int i = CH - 1; i >= 0; i--) begin
            if (p[i]) l = i;
        end
        return l;
    endfunction

    // New high word goes to the lowest lane pending when it was picked.
    always_comb begin
        lane_now = (wr_req && !req_d && !lo_next) ? lowest(pend_d) : lane_q;
        exp_addr = `SPC_ADDR_W'((int'(rec_win[lane_now]) * CH + lane_now) * 2 + int'(lo_next));
        exp_data = lo_next ? rec_cnt[lane_now][`SPC_DATA_W-1:0]
                           : rec_cnt[lane_now][`SPC_COUNT_W-1 -: `SPC_DATA_W];
    end

    ////////////////////////////////////////////////////////////
    // Reference window counts.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        logic [`SPC_COUNT_W-1:0] nxt;
        logic                    taken;
        if (!rst_n) begin
            {d1, d2, d3, rp} <= '0;
            for (int i = 0; i < CH; i++) begin
                cnt[i]     <= '0;
                rec_cnt[i] <= '0;
                rec_win[i] <= '0;
            end
            win       <= '0;
            pend      <= '0;
            pend_d    <= '0;
            ovr       <= 1'b0;
            seen_tick <= 1'b0;
            req_d     <= 1'b0;
            lo_next   <= 1'b0;
            lane_q    <= 0;
        end else begin
            d1     <= {sync_50hz, photon_in};
            d2     <= d1;
            d3     <= d2;
            rp     <= d2 & ~d3;  // Rising edge seen.
            req_d  <= wr_req;
            pend_d <= pend;
            if (wr_req) lane_q <= lane_now;
            if (wr_req && wr_done) lo_next <= !lo_next;  // Words alternate high and low.
            if (rp[CH]) begin
                seen_tick <= 1'b1;
                win <= (win == `SPC_WIN_W'(`SPC_FRAME_WINDOWS - 1)) ? '0 : win + 1'b1;
            end
            for (int i = 0; i < CH; i++) begin
                nxt   = (rp[i] && cnt[i] != '1) ? cnt[i] + 1'b1 : cnt[i];  // Saturate.
                taken = wr_req && wr_done && lo_next && lane_now == i;
                if (rp[CH]) begin
                    cnt[i] <= '0;
                    if (!pend[i] || taken) begin
                        pend[i]    <= 1'b1;
                        rec_cnt[i] <= nxt;  // Edge on the tick closes with it.
                        rec_win[i] <= win;
                    end else begin
                        ovr <= 1'b1;  // Lane still busy.
                    end
                end else begin
                    cnt[i] <= nxt;
                    if (taken) pend[i] <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !seen_tick |-> !wr_req && !overrun)
        else begin
            $error("wr_req or overrun high before the first window closed");
            fails++;
        end

    // An idle writer starts on a pending lane in the next cycle.
    a_start: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !wr_req && !lo_next && |pend |=> wr_req)
        else begin
            $error("wr_req did not rise for a pending lane");
            fails++;
        end

    a_lane_pending: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wr_req |-> pend[lane_now])
        else begin
            $error("Write request for lane %0d with no closed window", $sampled(lane_now));
            fails++;
        end

    a_addr: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wr_req |-> wr_cmd.addr == exp_addr)
        else begin
            $error("Mismatch write address: expected %h actual %h",
                   $sampled(exp_addr), $sampled(wr_cmd.addr));
            fails++;
        end

    a_data: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wr_req |-> wr_cmd.data == exp_data)
        else begin
            $error("Mismatch write data: expected %h actual %h",
                   $sampled(exp_data), $sampled(wr_cmd.data));
            fails++;
        end

    a_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wr_req && !wr_done |=> wr_req && $stable(wr_cmd))
        else begin
            $error("wr_req or wr_cmd changed before wr_done");
            fails++;
        end

    a_release: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wr_req && wr_done |=> !wr_req)
        else begin
            $error("wr_req still high in the cycle after wr_done");
            fails++;
        end

    a_overrun: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        overrun == ovr)
        else begin
            $error("Mismatch overrun: expected %b actual %b", $sampled(ovr), $sampled(overrun));
            fails++;
        end

endmodule

/* rtl/spc_photon_counter.sv */
`timescale 1ns/100ps
`include "spc_consts.svh"

module spc_photon_counter import spc_pkg::*; (
    input  logic                     clk_133MHz_210,
    input  logic                     rst_n,
    input  logic [`SPC_CHANNELS-1:0] photon_in,   // Photon pins.
    input  logic                     sync_50hz,   // Window sync pin.
    output logic                     wr_req,      // Toward frame memory.
    output mem_wr_t                  wr_cmd,
    input  logic                     wr_done,
    output logic                     overrun      // Sticky, any lane.
);

    logic [`SPC_CHANNELS-1:0] photon_pulse;
    logic                     window_tick;
    logic [`SPC_WIN_W-1:0]    window_idx;
    count_rec_t               lane_rec [`SPC_CHANNELS];
    logic [`SPC_CHANNELS-1:0] lane_pending;
    logic [`SPC_CHANNELS-1:0] lane_take;
    logic [`SPC_CHANNELS-1:0] lane_ovr;

    ////////////////////////////////////////////////////////////
    // Input side.
    ////////////////////////////////////////////////////////////

    spc_input_conditioner u_cond (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_in      (photon_in),
        .sync_50hz      (sync_50hz),
        .photon_pulse   (photon_pulse),
        .window_tick    (window_tick)
    );

    // One counter per lane.
    for (genvar g = 0; g < `SPC_CHANNELS; g++) begin : g_lane
        spc_channel_counter u_cnt (
            .clk_133MHz_210 (clk_133MHz_210),
            .rst_n          (rst_n),
            .photon_pulse   (photon_pulse[g]),
            .window_tick    (window_tick),
            .window_idx     (window_idx),
            .take           (lane_take[g]),
            .rec            (lane_rec[g]),
            .pending        (lane_pending[g]),
            .overrun        (lane_ovr[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // Memory side.
    ////////////////////////////////////////////////////////////

    spc_result_writer u_wr (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .window_tick    (window_tick),
        .recs           (lane_rec),
        .pending        (lane_pending),
        .take           (lane_take),
        .window_idx     (window_idx),
        .wr_req         (wr_req),
        .wr_cmd         (wr_cmd),
        .wr_done        (wr_done)
    );

    assign overrun = |lane_ovr;  // Any lane lost a window.

endmodule

/* rtl/spc_result_writer.sv */
`timescale 1ns/100ps
`include "spc_consts.svh"

module spc_result_writer import spc_pkg::*; (
    input  logic                     clk_133MHz_210,
    input  logic                     rst_n,
    input  logic                     window_tick,
    input  count_rec_t               recs [`SPC_CHANNELS],  // Lane results.
    input  logic [`SPC_CHANNELS-1:0] pending,
    output logic [`SPC_CHANNELS-1:0] take,                  // Frees a lane.
    output logic [`SPC_WIN_W-1:0]    window_idx,            // Current window.
    output logic                     wr_req,                // Level request.
    output mem_wr_t                  wr_cmd,
    input  logic                     wr_done                // One-cycle ack.
);

    localparam int LANE_W = $clog2(`SPC_CHANNELS);

    // Step machine, one request per word.
    typedef enum logic [1:0] {
        ST_IDLE,  // Look for a pending lane.
        ST_HIGH,  // High word requested.
        ST_ARM,   // Gap cycle, then low word.
        ST_LOW    // Low word requested.
    } state_t;

    state_t                  state_q;
    logic [LANE_W-1:0]       lane_q;     // Lane being written.
    logic [LANE_W-1:0]       pick;       // Lowest pending lane.
    logic                    any_pending;
    logic                    wr_req_q;
    logic [`SPC_WIN_W-1:0]   win_q;
    mem_wr_t                 wr_cmd_q;

    // ((win * channels + lane) * 2) + word.
    function automatic logic [`SPC_ADDR_W-1:0] word_addr(
        input logic [`SPC_WIN_W-1:0] win,
        input logic [LANE_W-1:0]     lane,
        input logic                  lo
    );
        logic [`SPC_ADDR_W-1:0] slot;
        slot      = `SPC_ADDR_W'(win) * `SPC_ADDR_W'(`SPC_CHANNELS) + `SPC_ADDR_W'(lane);
        word_addr = (slot << 1) + `SPC_ADDR_W'(lo);
    endfunction

    ////////////////////////////////////////////////////////////
    // Lane selection, lowest channel first.
    ////////////////////////////////////////////////////////////

    always_comb begin
        any_pending = |pending;
        pick        = '0;
        for (int i = `SPC_CHANNELS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = LANE_W'(i);
            end
        end
    end

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            lane_q   <= '0;
            wr_req_q <= 1'b0;
            win_q    <= '0;
        end else begin
            if (window_tick) begin  // Advance and wrap the window index.
                win_q <= (win_q == `SPC_WIN_W'(`SPC_FRAME_WINDOWS - 1)) ? '0 : win_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: if (any_pending) begin
                    lane_q   <= pick;
                    wr_req_q <= 1'b1;  // High word first.
                    state_q  <= ST_HIGH;
                end
                ST_HIGH: if (wr_done) begin
                    wr_req_q <= 1'b0;
                    state_q  <= ST_ARM;
                end
                ST_ARM: begin
                    wr_req_q <= 1'b1;  // Low word.
                    state_q  <= ST_LOW;
                end
                ST_LOW: if (wr_done) begin
                    wr_req_q <= 1'b0;
                    state_q  <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command stays put while wr_req is high.
    always_ff @(posedge clk_133MHz_210) begin
        if (state_q == ST_IDLE && any_pending) begin
            wr_cmd_q.addr <= word_addr(recs[pick].win, pick, 1'b0);
            wr_cmd_q.data <= recs[pick].count[`SPC_COUNT_W-1 -: `SPC_DATA_W];
        end else if (state_q == ST_ARM) begin
            wr_cmd_q.addr <= word_addr(recs[lane_q].win, lane_q, 1'b1);
            wr_cmd_q.data <= recs[lane_q].count[`SPC_DATA_W-1:0];
        end
    end

    // Clears pending on the low word's done edge.
    assign take = (state_q == ST_LOW && wr_done) ?
                  (`SPC_CHANNELS'(1) << lane_q) : '0;

    assign window_idx = win_q;
    assign wr_req     = wr_req_q;
    assign wr_cmd     = wr_cmd_q;

endmodule

/* rtl/spc_channel_counter.sv */
`timescale 1ns/100ps
`include "spc_consts.svh"

module spc_channel_counter import spc_pkg::*; (
    input  logic                  clk_133MHz_210,
    input  logic                  rst_n,
    input  logic                  photon_pulse,  // Conditioned lane pulse.
    input  logic                  window_tick,   // Window close.
    input  logic [`SPC_WIN_W-1:0] window_idx,    // Index of the closing window.
    input  logic                  take,          // Writer done with rec.
    output count_rec_t            rec,           // Held result.
    output logic                  pending,       // Rec waits for the writer.
    output logic                  overrun        // Sticky, a count was lost.
);

    logic [`SPC_COUNT_W-1:0] count_q;
    logic [`SPC_COUNT_W-1:0] count_nxt;  // Includes this cycle's pulse.
    logic                    pending_q;
    logic                    overrun_q;
    count_rec_t              rec_q;
    logic                    slot_free;

    // Saturate at all ones.
    assign count_nxt = (photon_pulse && count_q != '1) ? count_q + 1'b1 : count_q;

    // A take in the tick cycle frees the slot in time.
    assign slot_free = !pending_q || take;

    ////////////////////////////////////////////////////////////
    // Counter and control.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            pending_q <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            if (window_tick) begin
                count_q <= '0;  // New window starts empty.
                if (slot_free) begin
                    pending_q <= 1'b1;
                end else begin
                    overrun_q <= 1'b1;  // Old rec kept, new count dropped.
                end
            end else begin
                count_q <= count_nxt;
                if (take) begin
                    pending_q <= 1'b0;
                end
            end
        end
    end

    // Hold register for the finished window.
    always_ff @(posedge clk_133MHz_210) begin
        if (window_tick && slot_free) begin
            rec_q.count <= count_nxt;  // Pulse on the tick stays in this window.
            rec_q.win   <= window_idx;
        end
    end

    assign rec     = rec_q;
    assign pending = pending_q;
    assign overrun = overrun_q;

endmodule

/* rtl/spc_input_conditioner.sv */
`timescale 1ns/100ps
`include "spc_consts.svh"

module spc_input_conditioner (
    input  logic                     clk_133MHz_210,
    input  logic                     rst_n,
    input  logic [`SPC_CHANNELS-1:0] photon_in,     // Raw photon pins.
    input  logic                     sync_50hz,     // Raw 50Hz sync pin.
    output logic [`SPC_CHANNELS-1:0] photon_pulse,  // One pulse per rising edge.
    output logic                     window_tick    // Window close.
);

    // Sync rides along as the top bit.
    localparam int N = `SPC_CHANNELS + 1;

    logic [N-1:0] raw_in;
    logic [N-1:0] sync_q [`SPC_SYNC_STAGES];  // Synchronizer chain.
    logic [N-1:0] level_q;                    // Last sampled level.
    logic [N-1:0] edge_q;                     // Registered rising edge.

    assign raw_in = {sync_50hz, photon_in};

    ////////////////////////////////////////////////////////////
    // Synchronize, then catch rising edges.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `SPC_SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
            level_q <= '0;
            edge_q  <= '0;
        end else begin
            sync_q[0] <= raw_in;  // First stage, may go metastable.
            for (int s = 1; s < `SPC_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            level_q <= sync_q[`SPC_SYNC_STAGES-1];
            // High for one cycle when the level goes 0 -> 1.
            edge_q  <= sync_q[`SPC_SYNC_STAGES-1] & ~level_q;
        end
    end

    // Third cycle after the pin edge.
    assign photon_pulse = edge_q[`SPC_CHANNELS-1:0];
    assign window_tick  = edge_q[`SPC_CHANNELS];  // Shared by all lanes.

endmodule

/* rtl/spc_pkg.sv */
`include "spc_consts.svh"

package spc_pkg;

    ////////////////////////////////////////////////////////////
    // Lane result and memory write records.
    ////////////////////////////////////////////////////////////

    // Finished window count of one lane.
    typedef struct packed {
        logic [`SPC_COUNT_W-1:0] count;  // Photons in the window.
        logic [`SPC_WIN_W-1:0]   win;    // Window it belongs to.
    } count_rec_t;

    // One word toward frame memory.
    typedef struct packed {
        logic [`SPC_ADDR_W-1:0] addr;    // Word address.
        logic [`SPC_DATA_W-1:0] data;    // Half of a count.
    } mem_wr_t;

endpackage

/* rtl/spc_consts.svh */
`ifndef SPC_CONSTS_SVH
`define SPC_CONSTS_SVH

////////////////////////////////////////////////////////////
// Photon counter sizing.
////////////////////////////////////////////////////////////

`define SPC_CHANNELS      4     // Photon lanes.
`define SPC_COUNT_W       32    // Window count, saturating.
`define SPC_DATA_W        16    // Frame memory word.
`define SPC_ADDR_W        24    // Bank(2)+row(13)+column(9).

// Window index wraps after this many windows.
`define SPC_FRAME_WINDOWS 256
`define SPC_WIN_W         8     // Window index width.

// Input synchronizer depth.
`define SPC_SYNC_STAGES   2

`endif
